/* hdl/decode_pkg.sv */
package decode_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int num_alu_ops = 12;

    // one-hot alu line indices
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    localparam logic [reg_addr_w-1:0] rt_bltz  = 5'h00;
    localparam logic [reg_addr_w-1:0] rt_bgez  = 5'h01;
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    typedef struct packed {
        logic [xlen-1:0] inst;
        logic [xlen-1:0] pc;
    } fetch_to_decode_t;

    typedef struct packed {
        logic [num_alu_ops-1:0] alu_op;
        logic                   load;
        logic                   store;
        logic                   src1_is_sa;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   src2_is_uimm;
        logic                   src2_is_8;
        logic                   gr_we;
        logic [reg_addr_w-1:0]  dest;
        logic [15:0]            imm;
    } decode_ctrl_t;

    typedef struct packed {
        decode_ctrl_t    ctrl;
        logic [xlen-1:0] rs_value;
        logic [xlen-1:0] rt_value;
        logic [xlen-1:0] pc;
    } decode_to_exec_t;

    typedef struct packed {
        logic            bd;
        logic            taken;
        logic [xlen-1:0] target;
    } branch_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } rf_write_t;

    // pending write of a newer stage
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] dest;
        logic                  fwd_valid;
        logic [xlen-1:0]       fwd_data;
    } stage_dest_t;

endpackage

/* hdl/inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder
    import decode_pkg::*;
(
    input  logic [xlen-1:0]       inst,
    output decode_ctrl_t          ctrl,
    output logic [reg_addr_w-1:0] rs,
    output logic [reg_addr_w-1:0] rt,
    output logic                  jump_reg,
    output logic                  jump_imm,
    output logic [5:0]            br_cond
);

    logic [5:0]            op;
    logic [5:0]            func;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] sa;
    logic                  special;
    logic                  sa_zero;
    logic                  rs_zero;
    logic                  rt_zero;

    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic inst_j, inst_jal, inst_jr, inst_jalr;
    logic dst_is_rt;
    logic known;
    decode_ctrl_t c;

    assign op      = inst[31:26];
    assign rs      = inst[25:21];
    assign rt      = inst[20:16];
    assign rd      = inst[15:11];
    assign sa      = inst[10:6];
    assign func    = inst[5:0];
    assign special = (op == op_special);
    assign sa_zero = (sa == '0);
    assign rs_zero = (rs == '0);
    assign rt_zero = (rt == '0);

    assign inst_addu  = special && func == fn_addu && sa_zero;
    assign inst_subu  = special && func == fn_subu && sa_zero;
    assign inst_slt   = special && func == fn_slt  && sa_zero;
    assign inst_sltu  = special && func == fn_sltu && sa_zero;
    assign inst_and   = special && func == fn_and  && sa_zero;
    assign inst_or    = special && func == fn_or   && sa_zero;
    assign inst_xor   = special && func == fn_xor  && sa_zero;
    assign inst_nor   = special && func == fn_nor  && sa_zero;
    // immediate shifts carry the amount in sa, so rs must be zero
    assign inst_sll   = special && func == fn_sll  && rs_zero;
    assign inst_srl   = special && func == fn_srl  && rs_zero;
    assign inst_sra   = special && func == fn_sra  && rs_zero;
    assign inst_sllv  = special && func == fn_sllv && sa_zero;
    assign inst_srlv  = special && func == fn_srlv && sa_zero;
    assign inst_srav  = special && func == fn_srav && sa_zero;
    assign inst_jr    = special && func == fn_jr   && rt_zero && rd == '0 && sa_zero;
    assign inst_jalr  = special && func == fn_jalr && rt_zero && sa_zero;

    assign inst_addiu = (op == op_addiu);
    assign inst_slti  = (op == op_slti);
    assign inst_sltiu = (op == op_sltiu);
    assign inst_andi  = (op == op_andi);
    assign inst_ori   = (op == op_ori);
    assign inst_xori  = (op == op_xori);
    assign inst_lui   = (op == op_lui) && rs_zero;
    assign inst_lw    = (op == op_lw);
    assign inst_sw    = (op == op_sw);

    assign inst_beq   = (op == op_beq);
    assign inst_bne   = (op == op_bne);
    assign inst_bgez  = (op == op_regimm) && rt == rt_bgez;
    assign inst_bltz  = (op == op_regimm) && rt == rt_bltz;
    assign inst_bgtz  = (op == op_bgtz) && rt_zero;
    assign inst_blez  = (op == op_blez) && rt_zero;
    assign inst_j     = (op == op_j);
    assign inst_jal   = (op == op_jal);

    assign br_cond  = {inst_bltz, inst_blez, inst_bgtz, inst_bgez, inst_bne, inst_beq};
    assign jump_reg = inst_jr | inst_jalr;
    assign jump_imm = inst_j | inst_jal;

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori  | inst_lui  | inst_lw;

    assign known = inst_addu | inst_subu | inst_slt  | inst_sltu | inst_and  | inst_or
                 | inst_xor  | inst_nor  | inst_sll  | inst_srl  | inst_sra  | inst_sllv
                 | inst_srlv | inst_srav | dst_is_rt | inst_sw   | (|br_cond)
                 | jump_reg  | jump_imm;

    always_comb begin
        c = '0;
        // links compute pc + 8 on the add line
        c.alu_op[alu_add]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal | inst_jalr;
        c.alu_op[alu_sub]  = inst_subu;
        c.alu_op[alu_slt]  = inst_slt  | inst_slti;
        c.alu_op[alu_sltu] = inst_sltu | inst_sltiu;
        c.alu_op[alu_and]  = inst_and  | inst_andi;
        c.alu_op[alu_nor]  = inst_nor;
        c.alu_op[alu_or]   = inst_or   | inst_ori;
        c.alu_op[alu_xor]  = inst_xor  | inst_xori;
        c.alu_op[alu_sll]  = inst_sll  | inst_sllv;
        c.alu_op[alu_srl]  = inst_srl  | inst_srlv;
        c.alu_op[alu_sra]  = inst_sra  | inst_srav;
        c.alu_op[alu_lui]  = inst_lui;
        c.load         = inst_lw;
        c.store        = inst_sw;
        c.src1_is_sa   = inst_sll | inst_srl | inst_sra;
        c.src1_is_pc   = inst_jal | inst_jalr;
        c.src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
        c.src2_is_uimm = inst_andi | inst_ori | inst_xori;
        c.src2_is_8    = inst_jal | inst_jalr;
        c.gr_we        = known & ~inst_sw & ~(|br_cond) & ~inst_j & ~inst_jr;
        c.dest         = inst_jal ? link_reg : (dst_is_rt ? rt : rd);
        c.imm          = inst[15:0];
        ctrl = known ? c : '0;
    end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ns

module regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 always reads zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

/* hdl/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit
    import decode_pkg::*;
(
    input  logic [reg_addr_w-1:0] rs,
    input  logic [reg_addr_w-1:0] rt,
    input  decode_ctrl_t          ctrl,
    input  logic                  jump_imm,
    input  logic [xlen-1:0]       rf_rdata1,
    input  logic [xlen-1:0]       rf_rdata2,
    input  stage_dest_t           es_dest,
    input  stage_dest_t           ms_dest,
    input  stage_dest_t           ws_dest,
    output logic [xlen-1:0]       rs_value,
    output logic [xlen-1:0]       rt_value,
    output logic                  ready
);

    logic src1_used;
    logic src2_used;
    logic stall1;
    logic stall2;

    // result is {stall, value}
    // newest matching stage wins
    function automatic logic [xlen:0] resolve(
        input logic                  used,
        input logic [reg_addr_w-1:0] src,
        input logic [xlen-1:0]       rdata,
        input stage_dest_t           es,
        input stage_dest_t           ms,
        input stage_dest_t           ws
    );
        logic [xlen:0] r;
        r = {1'b0, rdata};
        if (used && es.we && es.dest == src) begin
            r = {!es.fwd_valid, es.fwd_data};
        end else if (used && ms.we && ms.dest == src) begin
            r = {!ms.fwd_valid, ms.fwd_data};
        end else if (used && ws.we && ws.dest == src) begin
            r = {!ws.fwd_valid, ws.fwd_data};
        end
        return r;
    endfunction

    assign src1_used = (rs != '0) && !ctrl.src1_is_sa && !jump_imm;
    // sw still reads rt as store data
    assign src2_used = (rt != '0) && !ctrl.src2_is_8
                     && (!(ctrl.src2_is_imm || ctrl.src2_is_uimm) || ctrl.store);

    assign {stall1, rs_value} = resolve(src1_used, rs, rf_rdata1, es_dest, ms_dest, ws_dest);
    assign {stall2, rt_value} = resolve(src2_used, rt, rf_rdata2, es_dest, ms_dest, ws_dest);

    assign ready = !stall1 && !stall2;

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit
    import decode_pkg::*;
(
    input  logic [5:0]      br_cond,
    input  logic            jump_reg,
    input  logic            jump_imm,
    input  logic [xlen-1:0] rs_value,
    input  logic [xlen-1:0] rt_value,
    input  logic [15:0]     imm,
    input  logic [25:0]     target_field,
    input  logic [xlen-1:0] pc,
    input  logic            valid,
    output branch_t         br
);

    logic [xlen-1:0] seq_pc;
    logic            rs_zero;
    logic            rs_neg;
    logic            cond_met;

    // delay slot address is also the branch base
    assign seq_pc  = pc + 32'd4;
    assign rs_zero = (rs_value == '0);
    assign rs_neg  = rs_value[xlen-1];

    // bit order beq, bne, bgez, bgtz, blez, bltz
    assign cond_met = (br_cond[0] &&  (rs_value == rt_value))
                   || (br_cond[1] &&  (rs_value != rt_value))
                   || (br_cond[2] && !rs_neg)
                   || (br_cond[3] && !rs_neg && !rs_zero)
                   || (br_cond[4] && (rs_neg || rs_zero))
                   || (br_cond[5] &&  rs_neg);

    assign br.bd     = (|br_cond) || jump_reg || jump_imm;
    assign br.taken  = (cond_met || jump_reg || jump_imm) && valid;
    assign br.target = (|br_cond) ? seq_pc + {{14{imm[15]}}, imm, 2'b00} :
                       jump_reg   ? rs_value :
                                    {seq_pc[31:28], target_field, 2'b00};

endmodule

/* hdl/id_stage.sv */
`timescale 1ns/1ns

module id_stage
    import decode_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             fs_to_ds_valid,
    input  fetch_to_decode_t fs_to_ds,
    output logic             ds_allowin,
    input  logic             es_allowin,
    output logic             ds_to_es_valid,
    output decode_to_exec_t  ds_to_es,
    output branch_t          br,
    input  rf_write_t        ws_write,
    input  stage_dest_t      es_dest,
    input  stage_dest_t      ms_dest,
    input  stage_dest_t      ws_dest
);

    logic                  ds_valid;
    logic                  ds_ready;
    fetch_to_decode_t      ds_data;
    decode_ctrl_t          ctrl;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic                  jump_reg;
    logic                  jump_imm;
    logic [5:0]            br_cond;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;
    logic [xlen-1:0]       rs_value;
    logic [xlen-1:0]       rt_value;

    assign ds_allowin     = !ds_valid || (ds_ready && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_data <= fs_to_ds;
        end
    end

    inst_decoder u_decoder (
        .inst     (ds_data.inst),
        .ctrl     (ctrl),
        .rs       (rs),
        .rt       (rt),
        .jump_reg (jump_reg),
        .jump_imm (jump_imm),
        .br_cond  (br_cond)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (ws_write.we),
        .waddr  (ws_write.addr),
        .wdata  (ws_write.data)
    );

    hazard_unit u_hazard (
        .rs        (rs),
        .rt        (rt),
        .ctrl      (ctrl),
        .jump_imm  (jump_imm),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .es_dest   (es_dest),
        .ms_dest   (ms_dest),
        .ws_dest   (ws_dest),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .ready     (ds_ready)
    );

    branch_unit u_branch (
        .br_cond      (br_cond),
        .jump_reg     (jump_reg),
        .jump_imm     (jump_imm),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .imm          (ds_data.inst[15:0]),
        .target_field (ds_data.inst[25:0]),
        .pc           (ds_data.pc),
        .valid        (ds_valid),
        .br           (br)
    );

    assign ds_to_es.ctrl     = ctrl;
    assign ds_to_es.rs_value = rs_value;
    assign ds_to_es.rt_value = rt_value;
    assign ds_to_es.pc       = ds_data.pc;

endmodule

/* dv/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // held for 8 rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* dv/tb_id_stage.sv */
`timescale 1ns/1ns

module tb_id_stage
    import decode_pkg::*;
();

    logic clk;
    logic reset;
    logic fs_to_ds_valid;
    fetch_to_decode_t fs_to_ds;
    logic ds_allowin;
    logic es_allowin;
    logic ds_to_es_valid;
    decode_to_exec_t ds_to_es;
    branch_t br;
    rf_write_t ws_write;
    stage_dest_t es_dest;
    stage_dest_t ms_dest;
    stage_dest_t ws_dest;

    logic [31:0] lfsr;
    logic [31:0] model_rf [32];
    int checks;
    int errors;

    clock_gen u_clk (.clk(clk), .reset(reset));

    id_stage UUT (
        .clk(clk), .reset(reset), .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds(fs_to_ds),
        .ds_allowin(ds_allowin), .es_allowin(es_allowin), .ds_to_es_valid(ds_to_es_valid),
        .ds_to_es(ds_to_es), .br(br), .ws_write(ws_write), .es_dest(es_dest),
        .ms_dest(ms_dest), .ws_dest(ws_dest)
    );

    // galois lfsr stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] reg_value(input logic [4:0] a);
        return (a == 5'd0) ? 32'd0 : model_rf[a];
    endfunction

    // kinds 0-10 r-type, 11-13 shift imm, 14 jr, 15 jalr, 16-24 imm and memory,
    // 25-32 branches and jumps, 33 unknown opcode
    function automatic logic [31:0] gen_inst(input int k, input logic [31:0] r);
        logic [5:0] r_fn [11];
        r_fn = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25, 6'h26, 6'h27, 6'h04, 6'h06, 6'h07};
        if (k <= 10) return {6'h00, r[25:11], 5'd0, r_fn[k]};
        if (k == 11) return {6'h00, 5'd0, r[20:6], 6'h00};
        if (k == 12) return {6'h00, 5'd0, r[20:6], 6'h02};
        if (k == 13) return {6'h00, 5'd0, r[20:6], 6'h03};
        if (k == 14) return {6'h00, r[25:21], 15'd0, 6'h08};
        if (k == 15) return {6'h00, r[25:21], 5'd0, r[15:11], 5'd0, 6'h09};
        if (k <= 21) return {6'h09 + 6'(k - 16), r[25:0]};
        if (k == 22) return {6'h0f, 5'd0, r[20:0]};
        if (k == 23) return {6'h23, r[25:0]};
        if (k == 24) return {6'h2b, r[25:0]};
        if (k == 25) return {6'h04, r[25:0]};
        if (k == 26) return {6'h05, r[25:0]};
        if (k == 27) return {6'h06, r[25:21], 5'd0, r[15:0]};
        if (k == 28) return {6'h07, r[25:21], 5'd0, r[15:0]};
        if (k == 29) return {6'h01, r[25:21], 5'd1, r[15:0]};
        if (k == 30) return {6'h01, r[25:21], 5'd0, r[15:0]};
        if (k == 31) return {6'h02, r[25:0]};
        if (k == 32) return {6'h03, r[25:0]};
        return {6'h3f, r[25:0]};
    endfunction

    function automatic decode_ctrl_t model_decode(input logic [31:0] inst);
        decode_ctrl_t c;
        logic ok;
        int alu;
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        op = inst[31:26];
        rs = inst[25:21];
        rt = inst[20:16];
        c = '0;
        alu = -1;
        c.dest = inst[15:11];
        ok = 1'b1;
        case (op)
            6'h00: begin
                ok = (inst[10:6] == 0);
                c.gr_we = 1'b1;
                case (inst[5:0])
                    6'h21: alu = alu_add;
                    6'h23: alu = alu_sub;
                    6'h2a: alu = alu_slt;
                    6'h2b: alu = alu_sltu;
                    6'h24: alu = alu_and;
                    6'h25: alu = alu_or;
                    6'h26: alu = alu_xor;
                    6'h27: alu = alu_nor;
                    6'h04: alu = alu_sll;
                    6'h06: alu = alu_srl;
                    6'h07: alu = alu_sra;
                    6'h00, 6'h02, 6'h03: begin
                        ok = (rs == 0);
                        c.src1_is_sa = 1'b1;
                        alu = (inst[5:0] == 0) ? alu_sll : (inst[1] && !inst[0]) ? alu_srl : alu_sra;
                    end
                    6'h08: begin
                        ok = ok && rt == 0 && inst[15:11] == 0;
                        c.gr_we = 1'b0;
                    end
                    6'h09: begin
                        ok = ok && rt == 0;
                        alu = alu_add;
                        c.src1_is_pc = 1'b1;
                        c.src2_is_8 = 1'b1;
                    end
                    default: ok = 1'b0;
                endcase
            end
            6'h09, 6'h0a, 6'h0b, 6'h0f, 6'h23: begin
                ok = (op != 6'h0f) || (rs == 0);
                c.gr_we = 1'b1;
                c.dest = rt;
                c.src2_is_imm = 1'b1;
                c.load = (op == 6'h23);
                alu = (op == 6'h0a) ? alu_slt : (op == 6'h0b) ? alu_sltu :
                      (op == 6'h0f) ? alu_lui : alu_add;
            end
            6'h0c, 6'h0d, 6'h0e: begin
                c.gr_we = 1'b1;
                c.dest = rt;
                c.src2_is_uimm = 1'b1;
                alu = (op == 6'h0c) ? alu_and : (op == 6'h0d) ? alu_or : alu_xor;
            end
            6'h2b: begin
                c.store = 1'b1;
                c.src2_is_imm = 1'b1;
                alu = alu_add;
            end
            6'h04, 6'h05, 6'h02: ok = 1'b1;
            6'h06, 6'h07: ok = (rt == 0);
            6'h01: ok = (rt == 0) || (rt == 1);
            6'h03: begin
                c.gr_we = 1'b1;
                c.dest = 5'd31;
                c.src1_is_pc = 1'b1;
                c.src2_is_8 = 1'b1;
                alu = alu_add;
            end
            default: ok = 1'b0;
        endcase
        if (!ok) return '0;
        c.imm = inst[15:0];
        if (alu >= 0) c.alu_op[alu] = 1'b1;
        return c;
    endfunction

    function automatic branch_t model_branch(input logic [31:0] inst, pc, rs_v, rt_v);
        branch_t b;
        logic [31:0] seq;
        logic [5:0] op;
        logic cond;
        logic is_cond;
        op = inst[31:26];
        seq = pc + 4;
        b = '0;
        cond = 1'b0;
        is_cond = 1'b1;
        case (op)
            6'h04: cond = (rs_v == rt_v);
            6'h05: cond = (rs_v != rt_v);
            6'h01: begin
                is_cond = (inst[20:16] <= 1);
                cond = (inst[20:16] == 1) ? ($signed(rs_v) >= 0) : ($signed(rs_v) < 0);
            end
            6'h06: begin
                is_cond = (inst[20:16] == 0);
                cond = ($signed(rs_v) <= 0);
            end
            6'h07: begin
                is_cond = (inst[20:16] == 0);
                cond = ($signed(rs_v) > 0);
            end
            default: is_cond = 1'b0;
        endcase
        if (is_cond) begin
            b = '{1'b1, cond, seq + {{14{inst[15]}}, inst[15:0], 2'b00}};
        end else if (op == 6'h02 || op == 6'h03) begin
            b = '{1'b1, 1'b1, {seq[31:28], inst[25:0], 2'b00}};
        end else if (op == 0 && inst[5:0] == 6'h08 && inst[20:6] == 0) begin
            b = '{1'b1, 1'b1, rs_v};
        end else if (op == 0 && inst[5:0] == 6'h09 && inst[20:16] == 0 && inst[10:6] == 0) begin
            b = '{1'b1, 1'b1, rs_v};
        end
        return b;
    endfunction

    task automatic compare(input string name, input logic [135:0] exp, input logic [135:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout: %s did not happen within 50 cycles", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic report_test(input string name, input int start);
        $display("test %s finished with %0d errors", name, errors - start);
    endtask

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        ws_write = '{1'b1, a, d};
        @(posedge clk);
        #1;
        ws_write.we = 1'b0;
        if (a != 0) model_rf[a] = d;
    endtask

    task automatic issue(input logic [31:0] inst, input logic [31:0] pc);
        int n;
        n = 0;
        fs_to_ds_valid = 1'b1;
        fs_to_ds = '{inst, pc};
        @(negedge clk);
        while (!ds_allowin) begin
            n++;
            if (n > 50) timeout_abort("ds_allowin rising");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic wait_output(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!ds_to_es_valid) begin
            cycles++;
            if (cycles > 50) timeout_abort("ds_to_es_valid rising");
            @(negedge clk);
        end
    endtask

    task automatic check_outputs(input logic [31:0] inst, pc, rs_v, rt_v);
        branch_t b;
        b = model_branch(inst, pc, rs_v, rt_v);
        compare("ds_to_es.ctrl", model_decode(inst), ds_to_es.ctrl);
        compare("ds_to_es.pc", pc, ds_to_es.pc);
        compare("ds_to_es.rs_value", rs_v, ds_to_es.rs_value);
        compare("ds_to_es.rt_value", rt_v, ds_to_es.rt_value);
        compare("br.bd", b.bd, br.bd);
        compare("br.taken", b.taken, br.taken);
        if (b.bd) compare("br.target", b.target, br.target);
    endtask

    // accept, wait for the output, check it, let execute take it
    task automatic run_one(input logic [31:0] inst, pc, rs_v, rt_v);
        int n;
        issue(inst, pc);
        wait_output(n);
        compare("output latency", 0, n);
        check_outputs(inst, pc, rs_v, rt_v);
        @(posedge clk);
        #1;
    endtask

    task automatic run_random(input int k);
        logic [31:0] inst;
        logic [31:0] r;
        r = lfsr_bits(32);
        if (lfsr_bits(1)) r[25:21] = 5'd0;
        if (lfsr_bits(1)) r[20:16] = r[25:21];
        inst = gen_inst(k, r);
        run_one(inst, lfsr_bits(30) << 2, reg_value(inst[25:21]), reg_value(inst[20:16]));
    endtask

    initial begin
        int start;
        int n;
        logic [4:0] a;
        logic [4:0] b;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] d3;
        logic [31:0] inst;
        decode_to_exec_t snap;
        fs_to_ds_valid = 1'b0;
        fs_to_ds = '0;
        es_allowin = 1'b1;
        ws_write = '0;
        es_dest = '0;
        ms_dest = '0;
        ws_dest = '0;
        lfsr = 32'hd0d8bc27;
        checks = 0;
        errors = 0;

        start = errors;
        n = 0;
        @(posedge clk);
        @(negedge clk);
        while (reset) begin
            compare("ds_to_es_valid", 0, ds_to_es_valid);
            compare("br.taken", 0, br.taken);
            compare("ds_allowin", 1, ds_allowin);
            n++;
            if (n > 50) timeout_abort("reset release");
            @(negedge clk);
        end
        compare("ds_to_es_valid", 0, ds_to_es_valid);
        compare("ds_allowin", 1, ds_allowin);
        @(posedge clk);
        #1;
        report_test("reset", start);

        start = errors;
        write_reg(5'd0, 32'hffffffff);
        for (int i = 1; i < 32; i++) write_reg(5'(i), lfsr_bits(32));
        run_one(32'h00000021, 32'h100, 32'd0, 32'd0);
        for (int i = 0; i < 30; i++) run_random(0);
        report_test("register operands", start);

        start = errors;
        for (int i = 0; i < 80; i++) run_random(lfsr_bits(6) % 34);
        report_test("decode", start);

        start = errors;
        a = 5'd1 + 5'(lfsr_bits(4));
        b = 5'd17 + 5'(lfsr_bits(3));
        d1 = lfsr_bits(32);
        d2 = lfsr_bits(32);
        d3 = lfsr_bits(32);
        es_dest = '{1'b1, a, 1'b0, d1};
        ms_dest = '{1'b1, a, 1'b1, d3};
        ws_dest = '{1'b1, b, 1'b0, d2};
        inst = {6'h00, a, b, 5'd3, 5'd0, 6'h21};
        issue(inst, 32'h2000);
        repeat (3) begin
            @(negedge clk);
            compare("ds_to_es_valid", 0, ds_to_es_valid);
            compare("ds_allowin", 0, ds_allowin);
        end
        @(posedge clk);
        #1;
        es_dest.fwd_valid = 1'b1;
        @(negedge clk);
        compare("ds_to_es_valid", 0, ds_to_es_valid);
        @(posedge clk);
        #1;
        ws_dest.fwd_valid = 1'b1;
        wait_output(n);
        check_outputs(inst, 32'h2000, d1, d2);
        @(posedge clk);
        #1;
        // ms ready ahead of a stalled ws
        es_dest = '0;
        ws_dest = '{1'b1, a, 1'b0, d2};
        run_one({6'h00, a, 5'd0, 5'd3, 5'd0, 6'h21}, 32'h2004, d3, 32'd0);
        ms_dest = '0;
        ws_dest = '0;
        report_test("hazards", start);

        start = errors;
        for (int i = 0; i < 60; i++) begin
            n = lfsr_bits(4) % 10;
            run_random(n < 2 ? 14 + n : 23 + n);
        end
        report_test("branches", start);

        start = errors;
        es_allowin = 1'b0;
        inst = gen_inst(4, lfsr_bits(32));
        issue(inst, 32'h3000);
        wait_output(n);
        check_outputs(inst, 32'h3000, reg_value(inst[25:21]), reg_value(inst[20:16]));
        snap = ds_to_es;
        @(posedge clk);
        #1;
        fs_to_ds_valid = 1'b1;
        fs_to_ds = '{gen_inst(1, lfsr_bits(32)), 32'h3004};
        repeat (4) begin
            @(negedge clk);
            compare("ds_to_es", snap, ds_to_es);
            compare("ds_allowin", 0, ds_allowin);
            compare("ds_to_es_valid", 1, ds_to_es_valid);
        end
        @(posedge clk);
        #1;
        es_allowin = 1'b1;
        inst = fs_to_ds.inst;
        run_one(inst, 32'h3004, reg_value(inst[25:21]), reg_value(inst[20:16]));
        report_test("back-pressure", start);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/hazard_unit.sv
hdl/branch_unit.sv
hdl/id_stage.sv
dv/clock_gen.sv
dv/tb_id_stage.sv
